// File: hw/bscBusPkg.sv
`default_nettype none

package bscBusPkg;

	typedef logic [31:0] addrT;	// CPU byte address
	typedef logic [26:0] extAddrT;	// External address pins
	typedef logic [31:0] dataT;
	typedef logic [3:0] byteEnT;	// Bit 3 is the lowest address byte
	typedef logic [1:0] areaT;	// Chip-select area, address bits 26..25

	typedef enum logic [1:0] {
		sizeNone,
		sizeByte,
		sizeWord,
		sizeLong
	} portSizeT;

	typedef enum logic [2:0] {
		stIdle,
		stT1,
		stTw,
		stT2,
		stRfs1,
		stRfs2
	} cycStateT;

	typedef struct packed {
		addrT addr;
		dataT wdata;
		byteEnT byteEn;
		logic we;
	} cpuReqT;

	typedef struct packed {
		extAddrT addr;
		dataT dout;	// Write data on the low lanes
		logic [3:0] csN;	// One per area
		logic bsN;
		logic rdN;
		logic rdWrN;
		byteEnT weN;
		logic rfs;
	} extBusT;

	localparam int refreshWaitCycles = 3;	// Length of rfs1

endpackage

`default_nettype wire

// File: hw/bscRegPkg.sv
`default_nettype none

package bscRegPkg;

	typedef logic [15:0] regWordT;

	// Port size and wait count per area
	typedef struct packed {
		bscBusPkg::portSizeT [3:0] areaSize;
		logic [3:0][1:0] waitCnt;
	} busCfgT;

	typedef struct packed {
		logic [2:0] clkSel;
		logic [7:0] compare;
		logic refreshEn;
	} timerCfgT;

	localparam regWordT regKey = 16'hA55A;	// Upper half of write data
	localparam bscBusPkg::addrT regBase = 32'hFFFFFFE0;

	localparam logic [4:0] offBcr2 = 5'h04;
	localparam logic [4:0] offWcr = 5'h08;
	localparam logic [4:0] offMcr = 5'h0C;
	localparam logic [4:0] offRtcsr = 5'h10;
	localparam logic [4:0] offRtcnt = 5'h14;
	localparam logic [4:0] offRtcor = 5'h18;

	localparam regWordT bcr2Wmask = 16'h00FC;	// A3SZ, A2SZ, A1SZ
	localparam regWordT bcr2Rmask = 16'h00FC;
	localparam regWordT bcr2Init = 16'h00FC;	// All areas long
	localparam regWordT wcrWmask = 16'h00FF;	// W3..W0
	localparam regWordT wcrRmask = 16'h00FF;
	localparam regWordT wcrInit = 16'h00FF;
	localparam regWordT mcrWmask = 16'h0004;	// RFSH
	localparam regWordT mcrRmask = 16'h0004;
	localparam regWordT mcrInit = 16'h0000;
	localparam regWordT rtcsrWmask = 16'h0038;	// CKS
	localparam regWordT rtcsrRmask = 16'h0038;
	localparam regWordT rtcsrInit = 16'h0000;
	localparam regWordT rtcntWmask = 16'h00FF;
	localparam regWordT rtcntRmask = 16'h00FF;
	localparam regWordT rtcntInit = 16'h0000;
	localparam regWordT rtcorWmask = 16'h00FF;
	localparam regWordT rtcorRmask = 16'h00FF;
	localparam regWordT rtcorInit = 16'h0000;

endpackage

`default_nettype wire

// File: hw/bscRegs.sv
`timescale 1ns/1ns
`default_nettype none

module bscRegs (
	input wire logic CLK,
	input wire logic RST_N,
	input wire logic regReq,
	input wire bscBusPkg::cpuReqT cpuReq,
	input wire bscBusPkg::portSizeT mdA0Size,
	input wire logic [7:0] cntValue,
	output bscRegPkg::busCfgT busCfg,
	output bscRegPkg::timerCfgT timerCfg,
	output logic cntWrite,
	output logic [7:0] cntWdata,
	output bscBusPkg::dataT regData,
	output logic regDone
);

	bscRegPkg::regWordT bcr2, wcr, mcr, rtcsr, rtcor;
	bscRegPkg::regWordT rdWord;
	logic [4:0] offset;
	logic keyOk;
	logic accept;
	logic wrEn;

	assign offset = {cpuReq.addr[4:2], 2'b00};
	assign keyOk = cpuReq.wdata[31:16] == bscRegPkg::regKey;
	assign accept = regReq && !regDone;	// One access per request
	assign wrEn = accept && cpuReq.we && keyOk;

	assign cntWrite = wrEn && offset == bscRegPkg::offRtcnt;
	assign cntWdata = cpuReq.wdata[7:0] & bscRegPkg::rtcntWmask[7:0];

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			bcr2 <= bscRegPkg::bcr2Init;
			wcr <= bscRegPkg::wcrInit;
			mcr <= bscRegPkg::mcrInit;
			rtcsr <= bscRegPkg::rtcsrInit;
			rtcor <= bscRegPkg::rtcorInit;
			regDone <= 1'b0;
		end else begin
			regDone <= accept;
			if (wrEn) begin
				case (offset)
					bscRegPkg::offBcr2: bcr2 <= cpuReq.wdata[15:0] & bscRegPkg::bcr2Wmask;
					bscRegPkg::offWcr: wcr <= cpuReq.wdata[15:0] & bscRegPkg::wcrWmask;
					bscRegPkg::offMcr: mcr <= cpuReq.wdata[15:0] & bscRegPkg::mcrWmask;
					bscRegPkg::offRtcsr: rtcsr <= cpuReq.wdata[15:0] & bscRegPkg::rtcsrWmask;
					bscRegPkg::offRtcor: rtcor <= cpuReq.wdata[15:0] & bscRegPkg::rtcorWmask;
					default: ;	// RTCNT lives in the timer
				endcase
			end
		end
	end

	always_comb begin
		case (offset)
			bscRegPkg::offBcr2: rdWord = bcr2 & bscRegPkg::bcr2Rmask;
			bscRegPkg::offWcr: rdWord = wcr & bscRegPkg::wcrRmask;
			bscRegPkg::offMcr: rdWord = mcr & bscRegPkg::mcrRmask;
			bscRegPkg::offRtcsr: rdWord = rtcsr & bscRegPkg::rtcsrRmask;
			bscRegPkg::offRtcnt: rdWord = {8'h00, cntValue} & bscRegPkg::rtcntRmask;
			bscRegPkg::offRtcor: rdWord = rtcor & bscRegPkg::rtcorRmask;
			default: rdWord = '0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (accept) regData <= {16'h0000, rdWord};
	end

	always_comb begin
		busCfg.areaSize[0] = mdA0Size;	// Area 0 from mode pins
		busCfg.areaSize[1] = bscBusPkg::portSizeT'(bcr2[3:2]);
		busCfg.areaSize[2] = bscBusPkg::portSizeT'(bcr2[5:4]);
		busCfg.areaSize[3] = bscBusPkg::portSizeT'(bcr2[7:6]);
		for (int i = 0; i < 4; i++) begin
			busCfg.waitCnt[i] = wcr[2*i +: 2];
		end
		timerCfg.clkSel = rtcsr[5:3];
		timerCfg.compare = rtcor[7:0];
		timerCfg.refreshEn = mcr[2];
	end

endmodule

`default_nettype wire

// File: hw/bscRefreshTimer.sv
`timescale 1ns/1ns
`default_nettype none

module bscRefreshTimer (
	input wire logic CLK,
	input wire logic RST_N,
	input wire bscRegPkg::timerCfgT timerCfg,
	input wire logic cntWrite,
	input wire logic [7:0] cntWdata,
	input wire logic refAck,
	output logic [7:0] cntValue,
	output logic refReq
);

	logic [11:0] prescaler;
	logic [7:0] cntNext;
	logic tick;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) prescaler <= '0;
		else prescaler <= prescaler + 12'd1;
	end

	// Divided tick from the free-running prescaler
	always_comb begin
		case (timerCfg.clkSel)
			3'd1: tick = &prescaler[1:0];
			3'd2: tick = &prescaler[3:0];
			3'd3: tick = &prescaler[5:0];
			3'd4: tick = &prescaler[7:0];
			3'd5: tick = &prescaler[9:0];
			3'd6: tick = &prescaler[10:0];
			3'd7: tick = &prescaler[11:0];
			default: tick = 1'b0;	// Count stopped
		endcase
	end

	assign cntNext = cntValue + 8'd1;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			cntValue <= bscRegPkg::rtcntInit[7:0];
			refReq <= 1'b0;
		end else begin
			if (refAck) refReq <= 1'b0;
			if (cntWrite) begin
				cntValue <= cntWdata;
			end else if (tick) begin
				if (cntNext == timerCfg.compare) begin
					cntValue <= '0;
					if (timerCfg.refreshEn) refReq <= 1'b1;	// Wins over a same-cycle ack
				end else begin
					cntValue <= cntNext;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/bscCycleCtrl.sv
`timescale 1ns/1ns
`default_nettype none

module bscCycleCtrl (
	input wire logic CLK,
	input wire logic RST_N,
	input wire logic extReq,
	input wire bscBusPkg::cpuReqT cpuReq,
	input wire bscRegPkg::busCfgT busCfg,
	input wire bscBusPkg::dataT din,
	input wire logic waitN,
	input wire logic refReq,
	output bscBusPkg::extBusT extBus,
	output logic refAck,
	output bscBusPkg::dataT extData,
	output logic extDone
);

	bscBusPkg::cycStateT state;
	logic [1:0] cycLeft;	// External cycles after the current one
	logic [1:0] waitLeft;
	logic [1:0] rfsCnt;

	bscBusPkg::extAddrT curAddr;
	bscBusPkg::dataT wbuf;
	bscBusPkg::byteEnT byteEn;
	bscBusPkg::areaT area;
	bscBusPkg::portSizeT size;
	logic we;
	logic [1:0] waits;

	bscBusPkg::areaT reqArea;
	bscBusPkg::portSizeT reqSize;
	logic [2:0] nBytes;
	logic [2:0] reqCycles;
	logic startAcc;
	logic busActive;
	logic [1:0] byteIdx;
	logic [2:0] step;
	bscBusPkg::dataT laneData;
	bscBusPkg::byteEnT laneWe;

	assign reqArea = cpuReq.addr[26:25];
	assign reqSize = busCfg.areaSize[reqArea];
	assign nBytes = {2'b00, cpuReq.byteEn[0]} + {2'b00, cpuReq.byteEn[1]} +
		{2'b00, cpuReq.byteEn[2]} + {2'b00, cpuReq.byteEn[3]};

	always_comb begin
		case (reqSize)
			bscBusPkg::sizeByte: reqCycles = nBytes;
			bscBusPkg::sizeWord: reqCycles = {1'b0, nBytes[2:1]};
			default: reqCycles = 3'd1;
		endcase
		if (reqCycles == 3'd0) reqCycles = 3'd1;	// Narrow access on a wider port
	end

	// Refresh goes first when both are pending
	assign startAcc = state == bscBusPkg::stIdle && !refReq && extReq && !extDone;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= bscBusPkg::stIdle;
			cycLeft <= '0;
			waitLeft <= '0;
			rfsCnt <= '0;
			refAck <= 1'b0;
			extDone <= 1'b0;
		end else begin
			refAck <= 1'b0;
			extDone <= 1'b0;
			case (state)
				bscBusPkg::stIdle: begin
					if (refReq) begin
						rfsCnt <= 2'(bscBusPkg::refreshWaitCycles - 1);
						refAck <= 1'b1;
						state <= bscBusPkg::stRfs1;
					end else if (startAcc) begin
						cycLeft <= 2'(reqCycles - 3'd1);
						state <= bscBusPkg::stT1;
					end
				end
				bscBusPkg::stT1: begin
					waitLeft <= (waits == 2'd0) ? 2'd0 : waits - 2'd1;
					if (waits == 2'd0 && waitN) state <= bscBusPkg::stT2;
					else state <= bscBusPkg::stTw;
				end
				bscBusPkg::stTw: begin
					if (waitLeft != 2'd0) waitLeft <= waitLeft - 2'd1;
					else if (waitN) state <= bscBusPkg::stT2;
				end
				bscBusPkg::stT2: begin
					if (cycLeft != 2'd0) begin
						cycLeft <= cycLeft - 2'd1;
						state <= bscBusPkg::stT1;
					end else begin
						extDone <= 1'b1;
						state <= bscBusPkg::stIdle;
					end
				end
				bscBusPkg::stRfs1: begin
					if (rfsCnt != 2'd0) rfsCnt <= rfsCnt - 2'd1;
					else state <= bscBusPkg::stRfs2;
				end
				default: state <= bscBusPkg::stIdle;	// rfs2
			endcase
		end
	end

	assign byteIdx = ~curAddr[1:0];	// Big-endian lane of the current byte

	always_comb begin
		case (size)
			bscBusPkg::sizeByte: step = 3'd1;
			bscBusPkg::sizeWord: step = 3'd2;
			default: step = 3'd4;
		endcase
	end

	// Request latch, address walk and read assembly
	always_ff @(posedge CLK) begin
		if (startAcc) begin
			curAddr <= cpuReq.addr[26:0];
			wbuf <= cpuReq.wdata;
			byteEn <= cpuReq.byteEn;
			we <= cpuReq.we;
			area <= reqArea;
			size <= reqSize;
			waits <= busCfg.waitCnt[reqArea];
		end else if (state == bscBusPkg::stT2 && cycLeft != 2'd0) begin
			curAddr <= curAddr + bscBusPkg::extAddrT'(step);
		end
		if (state == bscBusPkg::stT2 && !we) begin
			case (size)
				bscBusPkg::sizeByte: extData[8*byteIdx +: 8] <= din[7:0];
				bscBusPkg::sizeWord: begin
					if (curAddr[1]) extData[15:0] <= din[15:0];
					else extData[31:16] <= din[15:0];
				end
				default: extData <= din;
			endcase
		end
	end

	always_comb begin
		laneData = '0;
		laneWe = '0;
		case (size)
			bscBusPkg::sizeByte: begin
				laneData[7:0] = wbuf[8*byteIdx +: 8];
				laneWe[0] = byteEn[byteIdx];
			end
			bscBusPkg::sizeWord: begin
				laneData[15:0] = curAddr[1] ? wbuf[15:0] : wbuf[31:16];
				laneWe[1:0] = curAddr[1] ? byteEn[1:0] : byteEn[3:2];
			end
			default: begin
				laneData = wbuf;
				laneWe = byteEn;
			end
		endcase
	end

	assign busActive = state == bscBusPkg::stT1 || state == bscBusPkg::stTw ||
		state == bscBusPkg::stT2;

	always_comb begin
		extBus.addr = curAddr;
		extBus.dout = laneData;
		extBus.csN = busActive ? ~(4'b0001 << area) : 4'b1111;	// All high in refresh
		extBus.bsN = state != bscBusPkg::stT1;
		extBus.rdN = !(busActive && !we);
		extBus.rdWrN = !(busActive && we);
		extBus.weN = (busActive && we) ? ~laneWe : 4'b1111;
		extBus.rfs = state == bscBusPkg::stRfs1;
	end

endmodule

`default_nettype wire

// File: hw/bscTop.sv
`timescale 1ns/1ns
`default_nettype none

module bscTop (
	input wire logic CLK,
	input wire logic RST_N,
	input wire logic req,
	input wire bscBusPkg::cpuReqT cpuReq,
	input wire bscBusPkg::portSizeT mdA0Size,
	input wire bscBusPkg::dataT din,
	input wire logic waitN,
	output bscBusPkg::extBusT extBus,
	output bscBusPkg::dataT rdata,
	output logic busy
);

	bscRegPkg::busCfgT busCfg;
	bscRegPkg::timerCfgT timerCfg;
	logic [7:0] cntValue;
	logic [7:0] cntWdata;
	logic cntWrite;
	logic refReq;
	logic refAck;
	bscBusPkg::dataT regData;
	bscBusPkg::dataT extData;
	logic regDone;
	logic extDone;
	logic isReg;
	logic regReq;
	logic extReq;

	assign isReg = cpuReq.addr >= bscRegPkg::regBase;	// Register block on top
	assign regReq = req && isReg;
	assign extReq = req && !isReg;

	bscRegs i_regs (
		.CLK(CLK),
		.RST_N(RST_N),
		.regReq(regReq),
		.cpuReq(cpuReq),
		.mdA0Size(mdA0Size),
		.cntValue(cntValue),
		.busCfg(busCfg),
		.timerCfg(timerCfg),
		.cntWrite(cntWrite),
		.cntWdata(cntWdata),
		.regData(regData),
		.regDone(regDone)
	);

	bscRefreshTimer i_timer (
		.CLK(CLK),
		.RST_N(RST_N),
		.timerCfg(timerCfg),
		.cntWrite(cntWrite),
		.cntWdata(cntWdata),
		.refAck(refAck),
		.cntValue(cntValue),
		.refReq(refReq)
	);

	bscCycleCtrl i_cycle (
		.CLK(CLK),
		.RST_N(RST_N),
		.extReq(extReq),
		.cpuReq(cpuReq),
		.busCfg(busCfg),
		.din(din),
		.waitN(waitN),
		.refReq(refReq),
		.extBus(extBus),
		.refAck(refAck),
		.extData(extData),
		.extDone(extDone)
	);

	assign rdata = regDone ? regData : extData;
	assign busy = req && !(regDone || extDone);	// Low in the completing cycle

endmodule

`default_nettype wire

// File: dv/tbMemModel.svh
`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

bit [7:0] devMem [memSize];	// Seen by the external device
bit [7:0] refMem [memSize];	// Reference copy
int portOf [4];	// Port width per area in bytes

function automatic int memIdx(bscBusPkg::extAddrT a);
	return int'({a[26:25], a[7:0]});
endfunction

function automatic bit [7:0] fillByte(int i);
	return 8'(i * 37 + (i >> 8) * 11 + 5);
endfunction

// Device returns its whole port width, big-endian, on the low lanes
function automatic bscBusPkg::dataT devRead(bscBusPkg::extAddrT a, int p);
	bscBusPkg::dataT d;
	int base;
	d = '0;
	base = memIdx(a) & ~(p - 1);
	for (int i = 0; i < p; i++) d[8*(p-1-i) +: 8] = devMem[base + i];
	return d;
endfunction

task automatic devWrite(bscBusPkg::extAddrT a, int p, bscBusPkg::dataT dout,
		bscBusPkg::byteEnT weN);
	int base;
	base = memIdx(a) & ~(p - 1);
	for (int i = 0; i < p; i++) begin
		if (!weN[p-1-i]) devMem[base + i] = dout[8*(p-1-i) +: 8];
	end
endtask

// Lane 3 holds the lowest address byte
task automatic modelWrite(bscBusPkg::addrT addr, bscBusPkg::dataT wdata,
		bscBusPkg::byteEnT be);
	for (int l = 0; l < 4; l++) begin
		if (be[l]) refMem[(memIdx(addr[26:0]) & ~3) + 3 - l] = wdata[8*l +: 8];
	end
endtask

function automatic bscBusPkg::dataT modelRead(bscBusPkg::addrT addr);
	bscBusPkg::dataT d;
	for (int l = 0; l < 4; l++) d[8*l +: 8] = refMem[(memIdx(addr[26:0]) & ~3) + 3 - l];
	return d;
endfunction

`endif

// File: dv/tbBsc.sv
`timescale 1ns/1ns
`default_nettype none

module tbBsc;

	localparam int seed = 32'h72c3;
	localparam int numTx = 40;
	localparam int memSize = 1024;
	localparam int clkPeriod = 20;
	localparam int worstCycles = 4 * (2 + 3 + 6) + 6;	// Four external cycles with all waits
	localparam int timeoutCycles = 3 * numTx * worstCycles + 8 * 160 + 1000;

	logic CLK, RST_N, req, waitN;
	bscBusPkg::cpuReqT cpuReq;
	bscBusPkg::portSizeT mdA0Size;
	bscBusPkg::dataT din, rdata;
	bscBusPkg::extBusT extBus;
	logic busy;

	int cycleCnt, t1Cnt, rdLow, rfsHigh, lowLeft, stretchMode, fixedLen;
	logic rfsPrev;
	int rfsStart[$];
	bscBusPkg::extAddrT expAddr[$];
	bscBusPkg::byteEnT expWeN[$];
	bscBusPkg::dataT expDout[$];
	bscBusPkg::extAddrT curA;
	bscBusPkg::byteEnT curW;
	bscBusPkg::dataT curD;
	logic expWe;
	logic [3:0] expCs;

	`include "tbMemModel.svh"

	bscTop i_dut (
		.CLK(CLK),
		.RST_N(RST_N),
		.req(req),
		.cpuReq(cpuReq),
		.mdA0Size(mdA0Size),
		.din(din),
		.waitN(waitN),
		.extBus(extBus),
		.rdata(rdata),
		.busy(busy)
	);

	initial begin
		CLK = 1'b0;
		forever #(clkPeriod / 2) CLK = ~CLK;
	end

	initial begin
		#(timeoutCycles * clkPeriod);
		$display("Watchdog expired before the tests completed");
		$display("Simulation finished: FAIL");
		$fatal(1);
	end

	task automatic stopFail();
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic checkData(string name, bscBusPkg::dataT got, bscBusPkg::dataT exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
			stopFail();
		end
	endtask

	task automatic checkAddr(string name, bscBusPkg::extAddrT got, bscBusPkg::extAddrT exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
			stopFail();
		end
	endtask

	task automatic checkByteEn(string name, bscBusPkg::byteEnT got, bscBusPkg::byteEnT exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns %s: got %b, expected %b", $time, name, got, exp);
			stopFail();
		end
	endtask

	task automatic checkBit(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns %s: got %b, expected %b", $time, name, got, exp);
			stopFail();
		end
	endtask

	task automatic checkCount(string name, int got, int exp);
		if (got != exp) begin
			$display("[ERROR] %0t ns %s: got %0d, expected %0d", $time, name, got, exp);
			stopFail();
		end
	endtask

	// Bus monitor samples before the edge updates
	always @(posedge CLK) begin
		cycleCnt++;
		if (!extBus.rdN) rdLow++;
		if (!extBus.bsN) begin
			t1Cnt++;
			if (expAddr.size() == 0) begin
				$display("External bus cycle started with no access pending");
				stopFail();
			end
			curA = expAddr.pop_front();
			curW = expWeN.pop_front();
			curD = expDout.pop_front();
			expCs = 4'b1111;
			expCs[curA[26:25]] = 1'b0;
			checkAddr("extBus.addr", extBus.addr, curA);
			checkByteEn("extBus.csN", extBus.csN, expCs);
			checkBit("extBus.rdN", extBus.rdN, expWe);
			checkBit("extBus.rdWrN", extBus.rdWrN, !expWe);
			checkByteEn("extBus.weN", extBus.weN, curW);
			if (expWe) begin
				checkData("extBus.dout", extBus.dout, curD);
				devWrite(extBus.addr, portOf[extBus.addr[26:25]], extBus.dout, extBus.weN);
			end
		end
		if (extBus.rfs) begin
			checkByteEn("extBus.csN", extBus.csN, 4'b1111);
			if (!rfsPrev) rfsStart.push_back(cycleCnt);
			rfsHigh++;
		end else if (rfsPrev) begin
			checkCount("rfs high cycles", rfsHigh, bscBusPkg::refreshWaitCycles);
			rfsHigh = 0;
		end
		rfsPrev = extBus.rfs;
	end

	// Device responder
	always @(negedge CLK) begin
		din = devRead(extBus.addr, portOf[extBus.addr[26:25]]);
		if (!extBus.bsN) lowLeft = (stretchMode == 2) ? int'($urandom % 6) : fixedLen;
		if (lowLeft > 0) begin
			waitN = 1'b0;
			lowLeft--;
		end else waitN = 1'b1;
	end

	task automatic cpuAccess(bscBusPkg::addrT addr, bscBusPkg::dataT wdata,
			bscBusPkg::byteEnT be, logic we, output bscBusPkg::dataT rd);
		@(negedge CLK);
		cpuReq.addr = addr;
		cpuReq.wdata = wdata;
		cpuReq.byteEn = be;
		cpuReq.we = we;
		req = 1'b1;
		do @(negedge CLK); while (busy);
		rd = rdata;
		req = 1'b0;
	endtask

	task automatic regWrite(logic [4:0] off, bscRegPkg::regWordT v, bit keyed);
		bscBusPkg::dataT rd;
		cpuAccess(bscRegPkg::regBase + off, {keyed ? bscRegPkg::regKey : ~bscRegPkg::regKey, v},
			4'b1111, 1'b1, rd);
	endtask

	task automatic regCheck(logic [4:0] off, bscRegPkg::regWordT exp);
		bscBusPkg::dataT rd;
		cpuAccess(bscRegPkg::regBase + off, '0, 4'b1111, 1'b0, rd);
		checkData("rdata reg", rd, {16'h0000, exp});
	endtask

	// Expected bus cycles step the address by the port width
	task automatic extAccess(bscBusPkg::addrT addr, bscBusPkg::dataT wdata,
			bscBusPkg::byteEnT be, logic we, int n);
		int p, cyc, base, lane;
		bscBusPkg::extAddrT a;
		bscBusPkg::byteEnT w;
		bscBusPkg::dataT d, rd, mask;
		p = portOf[addr[26:25]];
		cyc = (n / p > 1) ? n / p : 1;
		for (int c = 0; c < cyc; c++) begin
			a = addr[26:0] + bscBusPkg::extAddrT'(c * p);
			base = int'(a[1:0]) & ~(p - 1);
			w = 4'b1111;
			d = '0;
			for (int i = 0; i < p; i++) begin
				lane = 3 - base - i;
				w[p-1-i] = !(we && be[lane]);
				d[8*(p-1-i) +: 8] = wdata[8*lane +: 8];
			end
			expAddr.push_back(a);
			expWeN.push_back(w);
			expDout.push_back(d);
		end
		t1Cnt = 0;
		rdLow = 0;
		expWe = we;
		cpuAccess(addr, wdata, be, we, rd);
		checkCount("t1 strobes", t1Cnt, cyc);
		checkCount("pending bus cycles", expAddr.size(), 0);
		for (int l = 0; l < 4; l++) mask[8*l +: 8] = {8{be[l]}};
		if (we) modelWrite(addr, wdata, be);
		else checkData("rdata", rd & mask, modelRead(addr) & mask);
	endtask

	task automatic randAccess(logic we, int nFix);
		int n, off;
		bscBusPkg::addrT addr;
		n = (nFix > 0) ? nFix : 1 << ($urandom % 3);
		off = ($urandom % 256) & ~(n - 1);
		addr = {5'b0, 2'($urandom % 4), 17'b0, 8'(off)};
		extAccess(addr, $urandom, 4'(((4'b1111 << (4 - n)) & 4'hF) >> (off % 4)), we, n);
	endtask

	initial begin
		logic [4:0] offs[5];
		bscRegPkg::regWordT wm[5], rm[5];
		bscRegPkg::regWordT v, bcr2, wcr;
		int clkSel, cmp, interval;

		void'($urandom(seed));
		req = 1'b0;
		cpuReq = '0;
		din = '0;
		waitN = 1'b1;
		mdA0Size = bscBusPkg::portSizeT'(2'($urandom % 3 + 1));
		RST_N = 1'b0;
		stretchMode = 0;
		fixedLen = 0;
		for (int i = 0; i < memSize; i++) begin
			devMem[i] = fillByte(i);
			refMem[i] = fillByte(i);
		end
		portOf[0] = 1 << (int'(mdA0Size) - 1);
		repeat (3) @(posedge CLK);
		@(negedge CLK);
		RST_N = 1'b1;

		offs = '{bscRegPkg::offBcr2, bscRegPkg::offWcr, bscRegPkg::offMcr,
			bscRegPkg::offRtcsr, bscRegPkg::offRtcor};
		wm = '{bscRegPkg::bcr2Wmask, bscRegPkg::wcrWmask, bscRegPkg::mcrWmask,
			bscRegPkg::rtcsrWmask, bscRegPkg::rtcorWmask};
		rm = '{bscRegPkg::bcr2Rmask, bscRegPkg::wcrRmask, bscRegPkg::mcrRmask,
			bscRegPkg::rtcsrRmask, bscRegPkg::rtcorRmask};
		for (int r = 0; r < 5; r++) begin
			v = 16'($urandom);
			regWrite(offs[r], v, 1'b1);
			regCheck(offs[r], v & wm[r] & rm[r]);
			regWrite(offs[r], ~v, 1'b0);	// Unkeyed write leaves the value
			regCheck(offs[r], v & wm[r] & rm[r]);
		end
		regWrite(bscRegPkg::offMcr, 16'h0000, 1'b1);
		regWrite(bscRegPkg::offRtcsr, 16'h0000, 1'b1);

		v = 16'($urandom);	// Counter is stopped here
		regWrite(bscRegPkg::offRtcnt, v, 1'b1);
		regCheck(bscRegPkg::offRtcnt, v & bscRegPkg::rtcntWmask & bscRegPkg::rtcntRmask);
		regWrite(bscRegPkg::offRtcnt, ~v, 1'b0);
		regCheck(bscRegPkg::offRtcnt, v & bscRegPkg::rtcntWmask & bscRegPkg::rtcntRmask);
		regWrite(bscRegPkg::offRtcnt, 16'h0000, 1'b1);
		regCheck(5'h1C, 16'h0000);	// Unknown offset

		bcr2 = '0;
		for (int a = 1; a < 4; a++) begin
			bcr2[2*a +: 2] = 2'($urandom % 3 + 1);
			portOf[a] = 1 << (int'(bcr2[2*a +: 2]) - 1);
		end
		regWrite(bscRegPkg::offBcr2, bcr2, 1'b1);
		stretchMode = 2;
		for (int t = 0; t < numTx; t++) randAccess(1'b0, 0);
		for (int t = 0; t < numTx; t++) randAccess(1'b1, 0);
		for (int i = 0; i < memSize; i++) checkData("memory byte", devMem[i], refMem[i]);

		stretchMode = 0;
		wcr = 16'($urandom % 256);
		regWrite(bscRegPkg::offWcr, wcr, 1'b1);
		for (int t = 0; t < numTx / 2; t++) begin
			randAccess(1'b0, 1);
			checkCount("rdN low cycles", rdLow, 2 + int'(wcr[2*int'(cpuReq.addr[26:25]) +: 2]));
		end
		regWrite(bscRegPkg::offWcr, 16'h0000, 1'b1);
		stretchMode = 1;
		for (int t = 0; t < numTx / 2; t++) begin
			fixedLen = $urandom % 5;
			randAccess(1'b0, 1);
			checkCount("rdN low cycles with waitN", rdLow, 2 + fixedLen);
		end
		fixedLen = 0;

		clkSel = $urandom % 2 + 1;
		cmp = $urandom % 8 + 3;
		interval = cmp * ((clkSel <= 4) ? (1 << (2 * clkSel)) : (1 << (clkSel + 5)));
		regWrite(bscRegPkg::offRtcor, 16'(cmp), 1'b1);
		regWrite(bscRegPkg::offRtcsr, 16'(clkSel << 3), 1'b1);
		regWrite(bscRegPkg::offMcr, 16'h0004, 1'b1);
		rfsStart.delete();
		while (rfsStart.size() < 4) @(posedge CLK);
		checkCount("rfs interval", rfsStart[2] - rfsStart[1], interval);
		checkCount("rfs interval", rfsStart[3] - rfsStart[2], interval);
		regWrite(bscRegPkg::offMcr, 16'h0000, 1'b1);
		repeat (10) @(posedge CLK);
		rfsStart.delete();
		repeat (3 * interval) @(posedge CLK);
		checkCount("rfs pulses with refresh off", rfsStart.size(), 0);

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
+incdir+dv
hw/bscBusPkg.sv
hw/bscRegPkg.sv
hw/bscRegs.sv
hw/bscRefreshTimer.sv
hw/bscCycleCtrl.sv
hw/bscTop.sv
dv/tbBsc.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tbBsc
RTL_TOP ?= bscTop
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation finished: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
